//--- qpu_exu_pkg.sv
// Execution unit decode types
package qpu_exu_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Instruction group

  typedef enum logic [1:0] {
    GRP_ALU  = 2'b00,  // Regular ALU
    GRP_BJP  = 2'b01,  // Branch compare
    GRP_RSV2 = 2'b10,
    GRP_RSV3 = 2'b11
  } exu_grp_e;

  ////////////////////////////////////////////////////////////////////////////
  // Operation field, two views of the same six bits

  // One-hot ALU operation plus operand 2 select
  typedef struct packed {
    logic add;
    logic sub;
    logic bxor;
    logic bor;
    logic band;
    logic op2imm;  // Operand 2 is the immediate
  } alu_info_t;

  // One-hot compare plus static prediction
  typedef struct packed {
    logic eq;
    logic ne;
    logic lt;    // Signed
    logic gt;    // Signed
    logic prdt;  // Predicted taken
    logic rsvd;
  } bjp_info_t;

  typedef union packed {
    alu_info_t alu;
    bjp_info_t bjp;
  } exu_op_u;

  // Decode-info word at the unit input
  typedef struct packed {
    exu_grp_e grp;
    exu_op_u  op;
  } exu_info_t;

  ////////////////////////////////////////////////////////////////////////////
  // Where a result goes

  // At most one of the write flags is set
  typedef struct packed {
    logic is_bjp;  // Commit carries branch bits
    logic wr_c;    // Classical register
    logic wr_qc;   // Quantum-classical register
    logic wr_t;    // Timing register
  } exu_route_t;

endpackage

//--- qpu_exu_decode.sv
// Execution unit decode
// Group select, operation view and write-back route
module qpu_exu_decode import qpu_exu_pkg::*; (
  input  exu_info_t  i_info,
  input  logic       i_ntp,
  input  logic       i_rdwen,
  input  logic       i_rd_qc,    // Top bit of rdidx
  output logic       o_is_alu,
  output exu_op_u    o_alu,
  output exu_route_t o_route,
  output logic       o_use_imm,
  output logic       o_time_op1
);

  logic is_bjp;

  assign o_is_alu = (i_info.grp == GRP_ALU);
  assign is_bjp   = (i_info.grp == GRP_BJP);

  // Pass only the view that belongs to the group
  always_comb begin
    o_alu = '0;
    case (i_info.grp)
      GRP_ALU: o_alu.alu = i_info.op.alu;
      GRP_BJP: o_alu.bjp = i_info.op.bjp;
      default: o_alu = '0;  // Reserved, nothing selected
    endcase
  end

  assign o_use_imm  = o_is_alu & i_info.op.alu.op2imm;
  assign o_time_op1 = o_is_alu & i_ntp;  // Wait adds to the time count

  ////////////////////////////////////////////////////////////////////////////
  // Write-back route

  // ntp wins over rdwen, branches write nothing
  always_comb begin
    o_route        = '0;
    o_route.is_bjp = is_bjp;
    if (o_is_alu) begin
      if (i_ntp) begin
        o_route.wr_t = 1'b1;
      end else if (i_rdwen) begin
        o_route.wr_qc = i_rd_qc;
        o_route.wr_c  = ~i_rd_qc;
      end
    end
  end

  // Dispatch only issues ALU or BJP groups to this unit
  always_comb begin
    assert (i_info.grp inside {GRP_ALU, GRP_BJP})
      else $error("exu decode: reserved group %b", i_info.grp);
  end

endmodule

//--- qpu_exu_dpath.sv
// Execution unit shared datapath
// One adder for ALU and branch compare
module qpu_exu_dpath import qpu_exu_pkg::*; #(
  parameter int XLEN   = 32,
  parameter int TIME_W = 24
) (
  input  logic              i_is_alu,
  input  exu_op_u           i_op,
  input  logic              i_use_imm,
  input  logic              i_time_op1,
  input  logic [XLEN-1:0]   i_rs1,
  input  logic [XLEN-1:0]   i_rs2,
  input  logic [XLEN-1:0]   i_imm,
  input  logic [TIME_W-1:0] i_time,
  output logic [XLEN-1:0]   o_res,
  output logic              o_cmp
);

  alu_info_t       alu_op;
  bjp_info_t       bjp_op;
  logic [XLEN-1:0] op1;
  logic [XLEN-1:0] op2;
  logic [XLEN-1:0] op2_add;
  logic            do_sub;
  logic [XLEN-1:0] sum;
  logic            ovf;
  logic            cmp_eq;
  logic            cmp_lt;
  logic            cmp_gt;

  assign alu_op = i_op.alu;
  assign bjp_op = i_op.bjp;

  // Operand select
  assign op1 = i_time_op1 ? XLEN'(i_time) : i_rs1;  // Zero-extended time count
  assign op2 = i_use_imm  ? i_imm : i_rs2;

  ////////////////////////////////////////////////////////////////////////////
  // Adder, subtracts for sub and every compare

  assign do_sub  = i_is_alu ? alu_op.sub : 1'b1;
  assign op2_add = do_sub ? ~op2 : op2;
  assign sum     = op1 + op2_add + XLEN'(do_sub);

  // Signed overflow of op1 - op2
  assign ovf    = (op1[XLEN-1] ^ op2[XLEN-1]) & (op1[XLEN-1] ^ sum[XLEN-1]);
  assign cmp_eq = (sum == '0);
  assign cmp_lt = sum[XLEN-1] ^ ovf;
  assign cmp_gt = ~cmp_lt & ~cmp_eq;

  assign o_cmp = ~i_is_alu & ((bjp_op.eq & cmp_eq)
                            | (bjp_op.ne & ~cmp_eq)
                            | (bjp_op.lt & cmp_lt)
                            | (bjp_op.gt & cmp_gt));

  // Result mux, one-hot and-or
  assign o_res = ({XLEN{i_is_alu & (alu_op.add | alu_op.sub)}} & sum)
               | ({XLEN{i_is_alu & alu_op.bxor}} & (op1 ^ op2))
               | ({XLEN{i_is_alu & alu_op.bor}}  & (op1 | op2))
               | ({XLEN{i_is_alu & alu_op.band}} & (op1 & op2));

  always_comb begin
    if (i_is_alu) begin
      assert ($onehot({alu_op.add, alu_op.sub, alu_op.bxor, alu_op.bor, alu_op.band}))
        else $error("exu dpath: ALU operation not one-hot");
    end
  end

endmodule

//--- qpu_exu_result.sv
// Execution unit result stage
// One-entry register feeding commit and write-back
module qpu_exu_result import qpu_exu_pkg::*; #(
  parameter int XLEN    = 32,
  parameter int TIME_W  = 24,
  parameter int RFIDX_W = 5,
  parameter int PC_W    = 32
) (
  input  logic               clk,
  input  logic               i_arst_n,
  // From datapath and decode
  input  logic               i_valid,
  output logic               o_ready,
  input  logic [XLEN-1:0]    i_res,
  input  logic               i_cmp,
  input  logic               i_prdt,
  input  exu_route_t         i_route,
  input  logic [PC_W-1:0]    i_pc,
  input  logic [RFIDX_W-1:0] i_rdidx,
  // Commit
  output logic               o_cmt_valid,
  input  logic               i_cmt_ready,
  output logic [PC_W-1:0]    o_cmt_pc,
  output logic               o_cmt_bjp,
  output logic               o_cmt_prdt,
  output logic               o_cmt_rslv,
  // Classical write-back
  output logic               o_cwbck_valid,
  input  logic               i_cwbck_ready,
  output logic [XLEN-1:0]    o_cwbck_data,
  output logic [RFIDX_W-1:0] o_cwbck_rdidx,
  // Quantum-classical write-back
  output logic               o_qcwbck_valid,
  input  logic               i_qcwbck_ready,
  output logic [XLEN-1:0]    o_qcwbck_data,
  output logic [RFIDX_W-1:0] o_qcwbck_rdidx,
  // Timing write-back
  output logic               o_twbck_valid,
  input  logic               i_twbck_ready,
  output logic [TIME_W-1:0]  o_twbck_data
);

  logic               full;
  logic               accept;
  logic               drain;
  logic               wb_ready;  // Ready of the one needed write-back
  logic [XLEN-1:0]    res_q;
  logic               cmp_q;
  logic               prdt_q;
  exu_route_t         route_q;
  logic [PC_W-1:0]    pc_q;
  logic [RFIDX_W-1:0] rdidx_q;

  always_comb begin
    if (route_q.wr_c)       wb_ready = i_cwbck_ready;
    else if (route_q.wr_qc) wb_ready = i_qcwbck_ready;
    else if (route_q.wr_t)  wb_ready = i_twbck_ready;
    else                    wb_ready = 1'b1;
  end

  // Leaves only when commit and its write-back go together
  assign drain   = full & i_cmt_ready & wb_ready;
  assign o_ready = ~full | drain;
  assign accept  = i_valid & o_ready;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      full <= 1'b0;
    end else if (accept | drain) begin
      full <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      res_q   <= i_res;
      cmp_q   <= i_cmp;
      prdt_q  <= i_prdt;
      route_q <= i_route;
      pc_q    <= i_pc;
      rdidx_q <= i_rdidx;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Output ports, each valid waits on its partner's ready

  assign o_cmt_valid = full & wb_ready;
  assign o_cmt_pc    = pc_q;
  assign o_cmt_bjp   = route_q.is_bjp;
  assign o_cmt_prdt  = route_q.is_bjp & prdt_q;
  assign o_cmt_rslv  = route_q.is_bjp & cmp_q;

  assign o_cwbck_valid  = full & route_q.wr_c & i_cmt_ready;
  assign o_cwbck_data   = res_q;
  assign o_cwbck_rdidx  = rdidx_q;
  assign o_qcwbck_valid = full & route_q.wr_qc & i_cmt_ready;
  assign o_qcwbck_data  = res_q;
  assign o_qcwbck_rdidx = rdidx_q;
  assign o_twbck_valid  = full & route_q.wr_t & i_cmt_ready;
  assign o_twbck_data   = res_q[TIME_W-1:0];  // Low bits only

  a_one_wbck: assert property (@(posedge clk) disable iff (!i_arst_n)
    $onehot0({o_cwbck_valid, o_qcwbck_valid, o_twbck_valid}));

  // Entry frozen while stalled
  a_hold: assert property (@(posedge clk) disable iff (!i_arst_n)
    full && !drain |=> $stable({res_q, cmp_q, prdt_q, route_q, pc_q, rdidx_q}));

endmodule

//--- qpu_exu_alu.sv
// Execution unit top
// Decode, shared datapath and result stage
module qpu_exu_alu import qpu_exu_pkg::*; #(
  parameter int XLEN    = 32,
  parameter int TIME_W  = 24,  // Not above XLEN
  parameter int RFIDX_W = 5,
  parameter int PC_W    = 32
) (
  input  logic               clk,
  input  logic               i_arst_n,
  // Instruction in
  input  logic               i_valid,
  output logic               o_ready,
  input  exu_info_t          i_info,
  input  logic [XLEN-1:0]    i_rs1,
  input  logic [XLEN-1:0]    i_rs2,
  input  logic [XLEN-1:0]    i_imm,
  input  logic [TIME_W-1:0]  i_time,
  input  logic               i_ntp,
  input  logic [RFIDX_W-1:0] i_rdidx,
  input  logic               i_rdwen,
  input  logic [PC_W-1:0]    i_pc,
  // Commit
  output logic               o_cmt_valid,
  input  logic               i_cmt_ready,
  output logic [PC_W-1:0]    o_cmt_pc,
  output logic               o_cmt_bjp,
  output logic               o_cmt_prdt,
  output logic               o_cmt_rslv,
  // Write-back ports
  output logic               o_cwbck_valid,
  input  logic               i_cwbck_ready,
  output logic [XLEN-1:0]    o_cwbck_data,
  output logic [RFIDX_W-1:0] o_cwbck_rdidx,
  output logic               o_qcwbck_valid,
  input  logic               i_qcwbck_ready,
  output logic [XLEN-1:0]    o_qcwbck_data,
  output logic [RFIDX_W-1:0] o_qcwbck_rdidx,
  output logic               o_twbck_valid,
  input  logic               i_twbck_ready,
  output logic [TIME_W-1:0]  o_twbck_data
);

  logic            is_alu;
  exu_op_u         op;
  exu_route_t      route;
  logic            use_imm;
  logic            time_op1;
  logic [XLEN-1:0] res;
  logic            cmp;

  qpu_exu_decode decode_i (
    .i_info     (i_info),
    .i_ntp      (i_ntp),
    .i_rdwen    (i_rdwen),
    .i_rd_qc    (i_rdidx[RFIDX_W-1]),
    .o_is_alu   (is_alu),
    .o_alu      (op),
    .o_route    (route),
    .o_use_imm  (use_imm),
    .o_time_op1 (time_op1)
  );

  qpu_exu_dpath #(.XLEN(XLEN), .TIME_W(TIME_W)) dpath_i (
    .i_is_alu   (is_alu),
    .i_op       (op),
    .i_use_imm  (use_imm),
    .i_time_op1 (time_op1),
    .i_rs1      (i_rs1),
    .i_rs2      (i_rs2),
    .i_imm      (i_imm),
    .i_time     (i_time),
    .o_res      (res),
    .o_cmp      (cmp)
  );

  qpu_exu_result #(
    .XLEN(XLEN), .TIME_W(TIME_W), .RFIDX_W(RFIDX_W), .PC_W(PC_W)
  ) result_i (
    .clk            (clk),
    .i_arst_n       (i_arst_n),
    .i_valid        (i_valid),
    .o_ready        (o_ready),
    .i_res          (res),
    .i_cmp          (cmp),
    .i_prdt         (op.bjp.prdt),  // Branch view, used only for branches
    .i_route        (route),
    .i_pc           (i_pc),
    .i_rdidx        (i_rdidx),
    .o_cmt_valid    (o_cmt_valid),
    .i_cmt_ready    (i_cmt_ready),
    .o_cmt_pc       (o_cmt_pc),
    .o_cmt_bjp      (o_cmt_bjp),
    .o_cmt_prdt     (o_cmt_prdt),
    .o_cmt_rslv     (o_cmt_rslv),
    .o_cwbck_valid  (o_cwbck_valid),
    .i_cwbck_ready  (i_cwbck_ready),
    .o_cwbck_data   (o_cwbck_data),
    .o_cwbck_rdidx  (o_cwbck_rdidx),
    .o_qcwbck_valid (o_qcwbck_valid),
    .i_qcwbck_ready (i_qcwbck_ready),
    .o_qcwbck_data  (o_qcwbck_data),
    .o_qcwbck_rdidx (o_qcwbck_rdidx),
    .o_twbck_valid  (o_twbck_valid),
    .i_twbck_ready  (i_twbck_ready),
    .o_twbck_data   (o_twbck_data)
  );

endmodule

//--- tb_qpu_exu_alu.sv
// Execution unit testbench
// Random instructions under output back-pressure
module tb_qpu_exu_alu import qpu_exu_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int XLEN      = 32;
  localparam int TIME_W    = 24;
  localparam int RFIDX_W   = 5;
  localparam int PC_W      = 32;
  localparam int N_INSTR   = 500;
  localparam int MAX_STALL = 16;  // Cycles allowed per instruction
  localparam int LIMIT     = 16 + N_INSTR * MAX_STALL + 100;

  // What one accepted instruction should produce
  typedef struct packed {
    logic [PC_W-1:0]    pc;
    exu_route_t         route;
    logic               prdt;
    logic               rslv;
    logic [XLEN-1:0]    data;
    logic [RFIDX_W-1:0] rdidx;
  } exp_t;

  logic clk, i_arst_n, i_valid, o_ready, i_ntp, i_rdwen;
  exu_info_t          i_info;
  logic [XLEN-1:0]    i_rs1, i_rs2, i_imm;
  logic [TIME_W-1:0]  i_time;
  logic [RFIDX_W-1:0] i_rdidx;
  logic [PC_W-1:0]    i_pc;
  logic               o_cmt_valid, i_cmt_ready, o_cmt_bjp, o_cmt_prdt, o_cmt_rslv;
  logic [PC_W-1:0]    o_cmt_pc;
  logic               o_cwbck_valid, i_cwbck_ready, o_qcwbck_valid, i_qcwbck_ready;
  logic [XLEN-1:0]    o_cwbck_data, o_qcwbck_data;
  logic [RFIDX_W-1:0] o_cwbck_rdidx, o_qcwbck_rdidx;
  logic               o_twbck_valid, i_twbck_ready;
  logic [TIME_W-1:0]  o_twbck_data;

  exp_t        exp_q[$];    // Acceptance order
  logic [31:0] rng = 32'h0f77_915a;
  int          n_acc = 0;
  int          n_val_err = 0;
  int          n_oth_err = 0;
  int          cycles = 0;

  qpu_exu_alu #(
    .XLEN(XLEN), .TIME_W(TIME_W), .RFIDX_W(RFIDX_W), .PC_W(PC_W)
  ) dut_i (.*);

  always #50 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Random source and reference model

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic exp_t predict(input exu_info_t info, input logic [XLEN-1:0] rs1,
      input logic [XLEN-1:0] rs2, input logic [XLEN-1:0] imm, input logic [TIME_W-1:0] tcnt,
      input logic ntp, input logic rdwen, input logic [RFIDX_W-1:0] rdidx,
      input logic [PC_W-1:0] pc);
    exp_t            e;
    alu_info_t       alu;
    bjp_info_t       bjp;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    e     = '0;
    alu   = info.op.alu;
    bjp   = info.op.bjp;
    e.pc  = pc;
    e.rdidx = rdidx;
    if (info.grp == GRP_BJP) begin
      e.route.is_bjp = 1'b1;
      e.prdt = bjp.prdt;
      e.rslv = (bjp.eq && rs1 == rs2) || (bjp.ne && rs1 != rs2)
            || (bjp.lt && $signed(rs1) < $signed(rs2))
            || (bjp.gt && $signed(rs1) > $signed(rs2));
    end else begin
      a = ntp ? {{(XLEN-TIME_W){1'b0}}, tcnt} : rs1;  // Wait adds to the time count
      b = alu.op2imm ? imm : rs2;
      if (alu.add)       e.data = a + b;
      else if (alu.sub)  e.data = a - b;
      else if (alu.bxor) e.data = a ^ b;
      else if (alu.bor)  e.data = a | b;
      else               e.data = a & b;
      if (ntp)        e.route.wr_t = 1'b1;
      else if (rdwen) begin
        e.route.wr_qc = rdidx[RFIDX_W-1];
        e.route.wr_c  = ~rdidx[RFIDX_W-1];
      end
    end
    return e;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks

  task automatic check_cmt(input logic [PC_W-1:0] pc, input logic bjp, input logic prdt,
                           input logic rslv, input exp_t e);
    if (pc !== e.pc) begin
      n_val_err++;
      $display("** Error: o_cmt_pc = %h, expected %h", pc, e.pc);
    end
    if ({bjp, prdt, rslv} !== {e.route.is_bjp, e.prdt, e.rslv}) begin
      n_val_err++;
      $display("** Error: o_cmt_bjp/prdt/rslv = %h, expected %h (pc %h)",
               {bjp, prdt, rslv}, {e.route.is_bjp, e.prdt, e.rslv}, e.pc);
    end
  endtask

  task automatic check_wbck(input string port, input logic [XLEN-1:0] data,
                            input logic [RFIDX_W-1:0] rdidx, input exp_t e);
    if (data !== e.data) begin
      n_val_err++;
      $display("** Error: %s_data = %h, expected %h (pc %h)", port, data, e.data, e.pc);
    end
    if (rdidx !== e.rdidx) begin
      n_val_err++;
      $display("** Error: %s_rdidx = %h, expected %h (pc %h)", port, rdidx, e.rdidx, e.pc);
    end
  endtask

  task automatic check_time(input logic [TIME_W-1:0] data, input exp_t e);
    if (data !== e.data[TIME_W-1:0]) begin
      n_val_err++;
      $display("** Error: o_twbck_data = %h, expected %h (pc %h)",
               data, e.data[TIME_W-1:0], e.pc);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus

  task automatic drive_readies();
    rng = xorshift32(rng);
    i_cmt_ready    = (rng[1:0] != 2'b00);  // Low about one cycle in four
    i_cwbck_ready  = (rng[3:2] != 2'b00);
    i_qcwbck_ready = (rng[5:4] != 2'b00);
    i_twbck_ready  = (rng[7:6] != 2'b00);
  endtask

  task automatic new_instr();
    logic [31:0] r;
    alu_info_t   alu;
    bjp_info_t   bjp;
    rng = xorshift32(rng);
    r   = rng;
    alu = '0;
    bjp = '0;
    if (!r[0]) begin
      case (int'(r[3:1]) % 5)
        0:       alu.add  = 1'b1;
        1:       alu.sub  = 1'b1;
        2:       alu.bxor = 1'b1;
        3:       alu.bor  = 1'b1;
        default: alu.band = 1'b1;
      endcase
      alu.op2imm  = r[4];
      i_info.grp  = GRP_ALU;
      i_info.op.alu = alu;
    end else begin
      case (r[2:1])
        2'd0:    bjp.eq = 1'b1;
        2'd1:    bjp.ne = 1'b1;
        2'd2:    bjp.lt = 1'b1;
        default: bjp.gt = 1'b1;
      endcase
      bjp.prdt    = r[4];
      bjp.rsvd    = r[5];
      i_info.grp  = GRP_BJP;
      i_info.op.bjp = bjp;
    end
    i_ntp   = (r[7:6] == 2'b00);
    i_rdwen = (r[9:8] != 2'b00);
    rng = xorshift32(rng);
    i_rs1 = rng;
    rng = xorshift32(rng);
    i_rs2 = (r[11:10] == 2'b00) ? i_rs1 : rng;  // Equal operands now and then
    rng = xorshift32(rng);
    i_imm = rng;
    rng = xorshift32(rng);
    i_time  = rng[TIME_W-1:0];
    i_rdidx = rng[31:32-RFIDX_W];
    i_pc    = i_pc + PC_W'(4);  // Unique pc per instruction
    i_valid = 1'b1;
  endtask

  initial begin
    logic taken;
    taken = 1'b0;
    clk = 1'b0;
    i_arst_n = 1'b0;
    i_valid = 1'b0;
    i_info = '0;
    i_info.op.alu.add = 1'b1;  // Legal word while idle
    {i_rs1, i_rs2, i_imm, i_time, i_ntp, i_rdidx, i_rdwen} = '0;
    i_pc = '0;
    {i_cmt_ready, i_cwbck_ready, i_qcwbck_ready, i_twbck_ready} = '0;
    repeat (16) @(posedge clk);
    #5 i_arst_n = 1'b1;
    @(negedge clk);
    if (!o_ready || o_cmt_valid || o_cwbck_valid || o_qcwbck_valid || o_twbck_valid) begin
      n_oth_err++;
      $display("After reset the unit is not idle with o_ready high");
    end
    while (n_acc < N_INSTR) begin
      @(posedge clk);
      #5;
      drive_readies();
      if (!i_valid || taken) begin  // Previous one taken at this edge
        i_valid = 1'b0;
        if (rng[10:8] != 3'b000) new_instr();
      end
      @(negedge clk);
      taken = i_valid && o_ready;
      if (taken) begin
        exp_q.push_back(predict(i_info, i_rs1, i_rs2, i_imm, i_time, i_ntp,
                                i_rdwen, i_rdidx, i_pc));
        n_acc++;
      end
    end
    @(posedge clk);
    #5 i_valid = 1'b0;
    while (exp_q.size() != 0) begin
      @(posedge clk);
      #5 drive_readies();
    end
    repeat (8) @(posedge clk);  // Catch stray commits
    $display("Summary: %0d instructions, %0d value errors, %0d other errors",
             n_acc, n_val_err, n_oth_err);
    if (n_val_err == 0 && n_oth_err == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Output checking, sampled mid-cycle

  always @(negedge clk) begin
    exp_t e;
    logic [2:0] wb_fire;
    wb_fire = {o_cwbck_valid & i_cwbck_ready, o_qcwbck_valid & i_qcwbck_ready,
               o_twbck_valid & i_twbck_ready};
    if (i_arst_n && o_cmt_valid && i_cmt_ready) begin
      if (exp_q.size() == 0) begin
        n_oth_err++;
        $display("Commit of pc %h fired with no instruction outstanding", o_cmt_pc);
      end else begin
        e = exp_q.pop_front();
        check_cmt(o_cmt_pc, o_cmt_bjp, o_cmt_prdt, o_cmt_rslv, e);
        if ({o_cwbck_valid, o_qcwbck_valid, o_twbck_valid}
            !== {e.route.wr_c, e.route.wr_qc, e.route.wr_t}) begin
          n_oth_err++;
          $display("Commit of pc %h fired without the matching write-back valid", e.pc);
        end
        if (e.route.wr_c)  check_wbck("o_cwbck", o_cwbck_data, o_cwbck_rdidx, e);
        if (e.route.wr_qc) check_wbck("o_qcwbck", o_qcwbck_data, o_qcwbck_rdidx, e);
        if (e.route.wr_t)  check_time(o_twbck_data, e);
      end
    end else if (i_arst_n && wb_fire != 3'b000) begin
      n_oth_err++;
      $display("A write-back fired without a commit in the same cycle");
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= LIMIT) begin
      $display("Timeout after %0d cycles with %0d of %0d instructions accepted",
               cycles, n_acc, N_INSTR);
      $display("Test failed");
      $finish;
    end
  end

endmodule

//--- qpu_exu_alu.f
qpu_exu_pkg.sv
qpu_exu_decode.sv
qpu_exu_dpath.sv
qpu_exu_result.sv
qpu_exu_alu.sv
tb_qpu_exu_alu.sv

//--- Makefile
# Verilator build for the execution unit testbench

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_qpu_exu_alu
FILELIST  = qpu_exu_alu.f
OBJDIR    = obj_dir
LOG       = sim.log
PASS_MSG  = Test passed

SOURCES   = $(shell cat $(FILELIST))
SIM_BIN   = $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# Pass or fail comes from the log
run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Simulation PASS"; \
	else \
		echo "Simulation FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)
